// File: rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

    typedef logic [31:0] rv_word_t;
    typedef logic [4:0]  reg_idx_t;

    // RV32I major opcodes handled by this slice
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        branch = 7'b1100011
    } opcode_e;

    // ALU ops follow funct3. 010 and 011 are free slots for sra and sub
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_e;

    // Same encoding as branch funct3
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_e;

    typedef enum logic {
        rs1_out = 1'b0,
        pc_out  = 1'b1
    } alumux1_sel_e;

    typedef enum logic {
        imm_out = 1'b0,
        rs2_out = 1'b1
    } alumux2_sel_e;

    typedef enum logic {
        cmp_rs2_out = 1'b0,
        cmp_imm_out = 1'b1 // slti, sltiu
    } cmpmux_sel_e;

    typedef enum logic [1:0] {
        pc_plus4        = 2'b00,
        alu_target      = 2'b01,
        alu_target_lsb0 = 2'b10 // jalr
    } pcmux_sel_e;

    typedef enum logic [1:0] {
        rf_alu_out  = 2'b00,
        rf_br_en    = 2'b01, // slt, sltu
        rf_u_imm    = 2'b10,
        rf_pc_plus4 = 2'b11
    } regfilemux_sel_e;

    typedef struct packed {
        alu_op_e      aluop;
        cmp_op_e      cmpop;
        alumux1_sel_e alumux1_sel;
        alumux2_sel_e alumux2_sel;
        cmpmux_sel_e  cmpmux_sel;
        pcmux_sel_e   pcmux_sel;
        logic         is_branch;
        logic         is_jump;
    } ctrl_ex_t;

    typedef struct packed {
        regfilemux_sel_e regfilemux_sel;
        logic            load_regfile;
        reg_idx_t        rd;
    } ctrl_wb_t;

    // ID/EX pipeline word
    typedef struct packed {
        logic     valid;
        rv_word_t pc;
        rv_word_t ir;
        rv_word_t rs1_val;
        rv_word_t rs2_val;
        rv_word_t imm;
        ctrl_ex_t ctrl_ex;
        ctrl_wb_t ctrl_wb;
    } id_ex_t;

    // Writeback request out of execute
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     we;
        rv_word_t wdata;
    } ex_result_t;

endpackage

`default_nettype wire

// File: rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  logic                  instr_valid,
    input  rv_pipe_pkg::rv_word_t instr,
    input  rv_pipe_pkg::rv_word_t pc,
    input  rv_pipe_pkg::rv_word_t rs1_val,
    input  rv_pipe_pkg::rv_word_t rs2_val,
    output rv_pipe_pkg::id_ex_t   id_word,
    output logic                  illegal
);
    import rv_pipe_pkg::*;

    opcode_e  opcode;
    logic [2:0] funct3;
    logic     funct7_b5;
    reg_idx_t rd_idx;
    rv_word_t imm_i;
    rv_word_t imm_u;
    rv_word_t imm_b;
    rv_word_t imm_j;
    rv_word_t imm;
    ctrl_ex_t ctrl_ex;
    ctrl_wb_t ctrl_wb;
    logic     writes_rd;
    logic     known;

    assign opcode    = opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30]; // sub, sra, srai
    assign rd_idx    = instr[11:7];

    assign imm_i = {{21{instr[31]}}, instr[30:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl_ex.aluop       = alu_add;
        ctrl_ex.cmpop       = beq;
        ctrl_ex.alumux1_sel = rs1_out;
        ctrl_ex.alumux2_sel = imm_out;
        ctrl_ex.cmpmux_sel  = cmp_rs2_out;
        ctrl_ex.pcmux_sel   = pc_plus4;
        ctrl_ex.is_branch   = 1'b0;
        ctrl_ex.is_jump     = 1'b0;
        ctrl_wb.regfilemux_sel = rf_alu_out;
        imm       = imm_i;
        writes_rd = 1'b0;
        known     = 1'b1;

        case (opcode)
            op, op_imm: begin
                writes_rd = 1'b1;
                ctrl_ex.aluop = alu_op_e'(funct3);
                if (opcode == op) begin
                    ctrl_ex.alumux2_sel = rs2_out;
                    if (funct3 == 3'b000 && funct7_b5)
                        ctrl_ex.aluop = alu_sub;
                end else begin
                    ctrl_ex.cmpmux_sel = cmp_imm_out;
                end
                if (funct3 == 3'b101 && funct7_b5)
                    ctrl_ex.aluop = alu_sra;
                // Set-less-than goes through the comparator
                if (funct3 == 3'b010) begin
                    ctrl_ex.cmpop = blt;
                    ctrl_wb.regfilemux_sel = rf_br_en;
                end else if (funct3 == 3'b011) begin
                    ctrl_ex.cmpop = bltu;
                    ctrl_wb.regfilemux_sel = rf_br_en;
                end
            end
            lui: begin
                writes_rd = 1'b1;
                imm = imm_u;
                ctrl_wb.regfilemux_sel = rf_u_imm;
            end
            auipc: begin
                writes_rd = 1'b1;
                imm = imm_u;
                ctrl_ex.alumux1_sel = pc_out;
            end
            jal: begin
                writes_rd = 1'b1;
                imm = imm_j;
                ctrl_ex.alumux1_sel = pc_out;
                ctrl_ex.pcmux_sel   = alu_target;
                ctrl_ex.is_jump     = 1'b1;
                ctrl_wb.regfilemux_sel = rf_pc_plus4; // Link
            end
            jalr: begin
                writes_rd = 1'b1;
                ctrl_ex.pcmux_sel = alu_target_lsb0;
                ctrl_ex.is_jump   = 1'b1;
                ctrl_wb.regfilemux_sel = rf_pc_plus4;
            end
            branch: begin
                imm = imm_b;
                ctrl_ex.cmpop       = cmp_op_e'(funct3);
                ctrl_ex.alumux1_sel = pc_out;
                ctrl_ex.pcmux_sel   = alu_target;
                ctrl_ex.is_branch   = 1'b1;
            end
            default: known = 1'b0;
        endcase

        // x0 is never written
        ctrl_wb.load_regfile = writes_rd && (rd_idx != 5'd0);
        ctrl_wb.rd = ctrl_wb.load_regfile ? rd_idx : 5'd0;
    end

    assign id_word = '{
        valid:   instr_valid && known,
        pc:      pc,
        ir:      instr,
        rs1_val: rs1_val,
        rs2_val: rs2_val,
        imm:     imm,
        ctrl_ex: ctrl_ex,
        ctrl_wb: ctrl_wb
    };

    assign illegal = instr_valid && !known;

    // Illegal opcodes leave as inert bubbles
    always_comb begin
        if (illegal)
            assert final (!id_word.valid && !id_word.ctrl_wb.load_regfile &&
                          !id_word.ctrl_ex.is_jump && !id_word.ctrl_ex.is_branch)
                else $error("rv_decode: illegal instruction is not an inert bubble");
    end

endmodule

`default_nettype wire

// File: rv_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module rv_stage_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                redirect,
    input  rv_pipe_pkg::id_ex_t in,
    output rv_pipe_pkg::id_ex_t out
);
    import rv_pipe_pkg::*;

    logic     load;
    logic     valid_q;
    ctrl_ex_t ctrl_ex_q;
    ctrl_wb_t ctrl_wb_q;
    rv_word_t pc_q;
    rv_word_t ir_q;
    rv_word_t rs1_q;
    rv_word_t rs2_q;
    rv_word_t imm_q;

    assign load = !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q               <= 1'b0;
            ctrl_ex_q.aluop       <= alu_add;
            ctrl_ex_q.cmpop       <= beq;
            ctrl_ex_q.alumux1_sel <= rs1_out;
            ctrl_ex_q.alumux2_sel <= imm_out;
            ctrl_ex_q.cmpmux_sel  <= cmp_rs2_out;
            ctrl_ex_q.pcmux_sel   <= pc_plus4;
            ctrl_ex_q.is_branch   <= 1'b0;
            ctrl_ex_q.is_jump     <= 1'b0;
            ctrl_wb_q.regfilemux_sel <= rf_alu_out;
            ctrl_wb_q.load_regfile   <= 1'b0;
            ctrl_wb_q.rd             <= 5'd0;
        end else if (load) begin
            valid_q   <= in.valid && !redirect; // Wrong-path slot squashed
            ctrl_ex_q <= in.ctrl_ex;
            ctrl_wb_q <= in.ctrl_wb;
        end
    end

    // Operand payload
    always_ff @(posedge clk) begin
        if (load) begin
            pc_q  <= in.pc;
            ir_q  <= in.ir;
            rs1_q <= in.rs1_val;
            rs2_q <= in.rs2_val;
            imm_q <= in.imm;
        end
    end

    assign out = '{
        valid:   valid_q,
        pc:      pc_q,
        ir:      ir_q,
        rs1_val: rs1_q,
        rs2_val: rs2_q,
        imm:     imm_q,
        ctrl_ex: ctrl_ex_q,
        ctrl_wb: ctrl_wb_q
    };

    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(out))
        else $error("rv_stage_reg: output changed under stall");

endmodule

`default_nettype wire

// File: rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  rv_pipe_pkg::id_ex_t     ex_word,
    output rv_pipe_pkg::ex_result_t result,
    output logic                    redirect,
    output rv_pipe_pkg::rv_word_t   redirect_pc
);
    import rv_pipe_pkg::*;

    ctrl_ex_t ctrl_ex;
    ctrl_wb_t ctrl_wb;
    rv_word_t alu_a;
    rv_word_t alu_b;
    rv_word_t cmp_b;
    rv_word_t alu_out;
    rv_word_t pc_next4;
    rv_word_t target;
    rv_word_t wdata;
    logic     br_en;

    assign ctrl_ex  = ex_word.ctrl_ex;
    assign ctrl_wb  = ex_word.ctrl_wb;
    assign pc_next4 = ex_word.pc + 32'd4;

    // Operand muxes
    assign alu_a = (ctrl_ex.alumux1_sel == pc_out)  ? ex_word.pc  : ex_word.rs1_val;
    assign alu_b = (ctrl_ex.alumux2_sel == rs2_out) ? ex_word.rs2_val : ex_word.imm;
    assign cmp_b = (ctrl_ex.cmpmux_sel == cmp_imm_out) ? ex_word.imm : ex_word.rs2_val;

    always_comb begin
        case (ctrl_ex.aluop)
            alu_add: alu_out = alu_a + alu_b;
            alu_sub: alu_out = alu_a - alu_b;
            alu_sll: alu_out = alu_a << alu_b[4:0];
            alu_srl: alu_out = alu_a >> alu_b[4:0];
            alu_sra: alu_out = rv_word_t'($signed(alu_a) >>> alu_b[4:0]);
            alu_xor: alu_out = alu_a ^ alu_b;
            alu_or:  alu_out = alu_a | alu_b;
            alu_and: alu_out = alu_a & alu_b;
            default: alu_out = alu_a + alu_b;
        endcase
    end

    // Comparator on rs1 against rs2 or imm
    always_comb begin
        case (ctrl_ex.cmpop)
            beq:     br_en = (ex_word.rs1_val == cmp_b);
            bne:     br_en = (ex_word.rs1_val != cmp_b);
            blt:     br_en = ($signed(ex_word.rs1_val) <  $signed(cmp_b));
            bge:     br_en = ($signed(ex_word.rs1_val) >= $signed(cmp_b));
            bltu:    br_en = (ex_word.rs1_val <  cmp_b);
            bgeu:    br_en = (ex_word.rs1_val >= cmp_b);
            default: br_en = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl_ex.pcmux_sel)
            alu_target:      target = alu_out;
            alu_target_lsb0: target = {alu_out[31:1], 1'b0};
            default:         target = pc_next4;
        endcase
    end

    assign redirect = ex_word.valid &&
                      (ctrl_ex.is_jump || (ctrl_ex.is_branch && br_en));
    assign redirect_pc = target;

    always_comb begin
        case (ctrl_wb.regfilemux_sel)
            rf_br_en:    wdata = {31'd0, br_en};
            rf_u_imm:    wdata = ex_word.imm;
            rf_pc_plus4: wdata = pc_next4;
            default:     wdata = alu_out;
        endcase
    end

    assign result = '{
        valid: ex_word.valid,
        rd:    ctrl_wb.rd,
        we:    ex_word.valid && ctrl_wb.load_regfile,
        wdata: wdata
    };

    // A redirect needs a valid slot and a real target
    always_comb begin
        if (redirect)
            assert final (ex_word.valid && ctrl_ex.pcmux_sel != pc_plus4)
                else $error("rv_execute: redirect from invalid slot or to pc+4");
    end

endmodule

`default_nettype wire

// File: rv_ex_slice.sv
`timescale 1ns/1ps
`default_nettype none

module rv_ex_slice (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    instr_valid,
    input  rv_pipe_pkg::rv_word_t   instr,
    input  rv_pipe_pkg::rv_word_t   pc,
    input  rv_pipe_pkg::rv_word_t   rs1_val,
    input  rv_pipe_pkg::rv_word_t   rs2_val,
    output rv_pipe_pkg::ex_result_t result,
    output logic                    redirect,
    output rv_pipe_pkg::rv_word_t   redirect_pc,
    output logic                    illegal
);
    import rv_pipe_pkg::*;

    id_ex_t id_word;
    id_ex_t ex_word; // ID/EX register output

    rv_decode u_decode (
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .id_word     (id_word),
        .illegal     (illegal)
    );

    rv_stage_reg u_stage (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .redirect (redirect),
        .in       (id_word),
        .out      (ex_word)
    );

    rv_execute u_execute (
        .ex_word     (ex_word),
        .result      (result),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

`default_nettype wire

// File: tb_rv_ex_slice.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_ex_slice;
    import rv_pipe_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 16;
    localparam int N_ALU      = 200;
    localparam int N_JUMP     = 60;
    localparam int N_BRANCH   = 120;
    localparam int N_STALL    = 150;
    localparam int N_ILLEGAL  = 30;
    localparam int MAX_STALL  = 3;
    localparam int N_TOTAL    = N_ALU + 2 * (N_JUMP + N_BRANCH + N_ILLEGAL) + N_STALL + 4;

    typedef struct packed {
        ex_result_t res;
        logic       redirect;
        rv_word_t   target;
    } exp_t;

    logic       clk;
    logic       rst;
    logic       stall;
    logic       instr_valid;
    rv_word_t   instr;
    rv_word_t   pc;
    rv_word_t   rs1_val;
    rv_word_t   rs2_val;
    ex_result_t result;
    logic       redirect;
    rv_word_t   redirect_pc;
    logic       illegal;

    exp_t  exp_q[$];
    string name_q[$];
    string test_name;
    logic  squash_next;
    int    mismatch_count;
    int    fail_count;
    int    retired;
    int    expected_retired;

    rv_ex_slice u_dut (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .result      (result),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .illegal     (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // OP, OP-IMM, LUI, AUIPC, JAL, JALR, BRANCH
    function automatic logic known_opcode(input logic [6:0] opc);
        return opc inside {7'h33, 7'h13, 7'h37, 7'h17, 7'h6f, 7'h67, 7'h63};
    endfunction

    function automatic exp_t ref_exec(input rv_word_t ins, input rv_word_t pc_v,
                                      input rv_word_t a, input rv_word_t b);
        exp_t       e;
        rv_word_t   imm_i;
        rv_word_t   opb;
        rv_word_t   val;
        logic [2:0] f3;
        logic       wr;
        logic       taken;
        f3 = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        opb = (ins[6:0] == 7'h33) ? b : imm_i;
        e = '0;
        val = '0;
        wr = 1'b0;
        taken = 1'b0;
        case (ins[6:0])
            7'h33, 7'h13: begin
                wr = 1'b1;
                case (f3)
                    3'd0: val = (ins[6:0] == 7'h33 && ins[30]) ? a - opb : a + opb;
                    3'd1: val = a << opb[4:0];
                    3'd2: val = {31'd0, $signed(a) < $signed(opb)};
                    3'd3: val = {31'd0, a < opb};
                    3'd4: val = a ^ opb;
                    3'd5: val = ins[30] ? rv_word_t'($signed(a) >>> opb[4:0]) : a >> opb[4:0];
                    3'd6: val = a | opb;
                    default: val = a & opb;
                endcase
            end
            7'h37, 7'h17: begin
                wr = 1'b1;
                val = {ins[31:12], 12'h000} + ((ins[6:0] == 7'h17) ? pc_v : 32'd0);
            end
            7'h6f, 7'h67: begin
                wr = 1'b1;
                taken = 1'b1;
                val = pc_v + 32'd4; // Link address
                if (ins[6:0] == 7'h6f)
                    e.target = pc_v + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                else
                    e.target = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) < $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    3'd6: taken = (a < b);
                    3'd7: taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                e.target = pc_v + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            default: ;
        endcase
        e.res.valid = known_opcode(ins[6:0]);
        e.res.we    = wr && (ins[11:7] != 5'd0);
        e.res.rd    = e.res.we ? ins[11:7] : 5'd0;
        e.res.wdata = val;
        e.redirect  = e.res.valid && taken;
        return e;
    endfunction

    // kind 0 alu, 1 lui, 2 auipc, 3 jal, 4 jalr, 5 branch, else illegal
    function automatic rv_word_t gen_instr(input int kind);
        rv_word_t   w;
        logic [2:0] f3;
        logic [6:0] opc;
        logic       alt;
        int         idx;
        w = $urandom;
        f3 = w[14:12];
        alt = 1'($urandom_range(0, 1));
        idx = $urandom_range(0, 5);
        case (kind)
            0: begin
                if ($urandom_range(0, 1) == 1) begin
                    w[31:25] = {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'd0};
                    opc = 7'h33;
                end else begin
                    if (f3 == 3'd1 || f3 == 3'd5)
                        w[31:25] = {1'b0, alt && (f3 == 3'd5), 5'd0}; // slli, srli, srai
                    opc = 7'h13;
                end
            end
            1: opc = 7'h37;
            2: opc = 7'h17;
            3: opc = 7'h6f;
            4: begin
                opc = 7'h67;
                w[14:12] = 3'd0;
            end
            5: begin
                opc = 7'h63;
                w[14:12] = (idx < 2) ? 3'(idx) : 3'(idx + 2);
            end
            default: begin
                do begin
                    opc = 7'($urandom);
                end while (known_opcode(opc));
            end
        endcase
        w[6:0] = opc;
        return w;
    endfunction

    task automatic compare_field(input string name, input string field,
                                 input rv_word_t exp_v, input rv_word_t act_v);
        assert (exp_v === act_v) else begin
            mismatch_count++;
            $display("Mismatch %s %s: expected %h actual %h", name, field, exp_v, act_v);
        end
    endtask

    // Holds one instruction on the inputs until a non-stalled edge takes it
    task automatic present(input rv_word_t ins, input logic vld, input int stall_pct);
        exp_t e;
        int   stalls;
        logic exp_illegal;
        instr = ins;
        instr_valid = vld;
        pc = $urandom & 32'hffff_fffc;
        rs1_val = $urandom;
        rs2_val = ($urandom_range(0, 3) == 0) ? rs1_val : $urandom; // beq/bge hits
        exp_illegal = vld && !known_opcode(ins[6:0]);
        stalls = 0;
        forever begin
            stall = (stalls < MAX_STALL) && ($urandom_range(0, 99) < stall_pct);
            #1;
            compare_field({test_name, " illegal"}, "flag", 32'(exp_illegal), 32'(illegal));
            @(posedge clk);
            if (!stall)
                break;
            stalls++;
            #1;
        end
        e = '0;
        if (vld)
            e = ref_exec(ins, pc, rs1_val, rs2_val);
        if (squash_next)
            e = '0; // Wrong path behind a redirect
        squash_next = e.redirect;
        exp_q.push_back(e);
        name_q.push_back(test_name);
        if (e.res.valid)
            expected_retired++;
        #1;
    endtask

    // Comparing process, mid-cycle where outputs are settled
    initial begin
        exp_t  cur;
        string name;
        cur = '0;
        name = "reset";
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            if (exp_q.size() > 0) begin
                cur = exp_q.pop_front();
                name = name_q.pop_front();
            end
            compare_field(name, "valid", 32'(cur.res.valid), 32'(result.valid));
            compare_field(name, "we", 32'(cur.res.we), 32'(result.we));
            compare_field(name, "redirect", 32'(cur.redirect), 32'(redirect));
            if (cur.res.valid)
                compare_field(name, "rd", 32'(cur.res.rd), 32'(result.rd));
            if (cur.res.we)
                compare_field(name, "wdata", cur.res.wdata, result.wdata);
            if (cur.redirect)
                compare_field(name, "redirect_pc", cur.target, redirect_pc);
            if (!stall && result.valid === 1'b1)
                retired++;
        end
    end

    initial begin
        #((RST_CYCLES + N_TOTAL * (MAX_STALL + 1) + 50) * CLK_PERIOD);
        fail_count++;
        $display("Watchdog timeout, the stimulus did not finish in time");
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h451d));
        rst = 1'b1;
        stall = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        rs1_val = '0;
        rs2_val = '0;
        squash_next = 1'b0;
        mismatch_count = 0;
        fail_count = 0;
        retired = 0;
        expected_retired = 0;
        test_name = "reset";
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        test_name = "alu";
        repeat (N_ALU) present(gen_instr(0), 1'b1, 0);
        test_name = "upper_jump";
        repeat (N_JUMP) begin
            present(gen_instr($urandom_range(1, 4)), 1'b1, 0);
            present(gen_instr(0), 1'b1, 0);
        end
        test_name = "branch";
        repeat (N_BRANCH) begin
            present(gen_instr(5), 1'b1, 0);
            present(gen_instr(0), 1'b1, 0);
        end
        test_name = "stall";
        repeat (N_STALL) present(gen_instr($urandom_range(0, 5)), 1'b1, 40);
        test_name = "illegal";
        repeat (N_ILLEGAL) begin
            present(gen_instr(6), 1'b1, 0);
            present(gen_instr(0), 1'b1, 0);
        end
        test_name = "flush";
        repeat (4) present('0, 1'b0, 0);
        @(negedge clk);
        #1;

        assert (retired == expected_retired) else begin
            mismatch_count++;
            $display("Mismatch retire_count: expected %0d actual %0d",
                     expected_retired, retired);
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
rv_pipe_pkg.sv
rv_decode.sv
rv_stage_reg.sv
rv_execute.sv
rv_ex_slice.sv
tb_rv_ex_slice.sv

// File: Bender.yml
package:
  name: rv_ex_slice

sources:
  - files:
      - rv_pipe_pkg.sv
      - rv_decode.sv
      - rv_stage_reg.sv
      - rv_execute.sv
      - rv_ex_slice.sv

  - target: simulation
    files:
      - tb_rv_ex_slice.sv

# Testbench top is tb_rv_ex_slice, RTL top is rv_ex_slice
